// ==== src.f ====
hw/sm3_expnd_pkg.sv
hw/sm3_expnd_ctrl.sv
hw/sm3_prefetch_buf.sv
hw/sm3_word_window.sv
hw/sm3_expnd_out.sv
hw/sm3_expnd_core.sv
verification/tb_clk_gen.sv
verification/sm3_expnd_tb.sv

// ==== verification/sm3_expnd_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm3_expnd_tb;

    localparam int TOTAL_BLOCKS    = 9;
    localparam int WATCHDOG_CYCLES = 200 * TOTAL_BLOCKS + 1000;

    typedef enum int {GAP_NONE, GAP_RAND, GAP_SLOW_PRE} gap_mode_t;

    wire                  clk;
    logic                 rst_n;
    sm3_expnd_pkg::word_t pad_word_i;
    logic                 pad_vld_i;
    logic                 pad_lst_i;
    wire                  pad_rdy_o;
    sm3_expnd_pkg::word_t expnd_wj_o;
    sm3_expnd_pkg::word_t expnd_wjj_o;
    wire                  expnd_vld_o;
    wire                  expnd_lst_o;

    logic [31:0]          lfsr_q = 32'hda38_2432;
    sm3_expnd_pkg::word_t exp_wj[$];
    sm3_expnd_pkg::word_t exp_wjj[$];
    logic                 exp_lst[$];
    int                   mismatch_cnt = 0;
    int                   other_cnt    = 0;
    int                   pair_cnt     = 0;
    int                   blocks_sent  = 0;

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    sm3_expnd_core dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pad_word_i  (pad_word_i),
        .pad_vld_i   (pad_vld_i),
        .pad_lst_i   (pad_lst_i),
        .pad_rdy_o   (pad_rdy_o),
        .expnd_wj_o  (expnd_wj_o),
        .expnd_wjj_o (expnd_wjj_o),
        .expnd_vld_o (expnd_vld_o),
        .expnd_lst_o (expnd_lst_o)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic sm3_expnd_pkg::word_t rot_left(input sm3_expnd_pkg::word_t x,
                                                      input int n);
        logic [63:0] dbl;
        dbl      = {x, x} << n;
        rot_left = dbl[63:32];
    endfunction

    function automatic sm3_expnd_pkg::word_t perm_p1(input sm3_expnd_pkg::word_t x);
        perm_p1 = x ^ rot_left(x, 15) ^ rot_left(x, 23);
    endfunction

    // expected {W_j, W'_j} for j = 0..63
    function automatic logic [63:0][63:0] expand_ref(input logic [15:0][31:0] blk);
        sm3_expnd_pkg::word_t w [68];
        logic [63:0][63:0]    res;
        for (int j = 0; j < 16; j++) begin
            w[j] = blk[j];
        end
        for (int j = 16; j < 68; j++) begin
            w[j] = perm_p1(w[j-16] ^ w[j-9] ^ rot_left(w[j-3], 15))
                 ^ rot_left(w[j-13], 7) ^ w[j-6];
        end
        for (int j = 0; j < 64; j++) begin
            res[j] = {w[j], w[j] ^ w[j+4]};
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, expected);
        end
    endtask

    task automatic send_word(input sm3_expnd_pkg::word_t w, input logic lst, input int gap);
        repeat (gap) begin
            @(negedge clk);
            pad_vld_i = 1'b0;
            pad_lst_i = 1'b0;
        end
        @(negedge clk);
        pad_word_i = w;
        pad_vld_i  = 1'b1;
        pad_lst_i  = lst;
        while (!pad_rdy_o) begin
            @(negedge clk);   // hold until ready
        end
    endtask

    task automatic send_block(input gap_mode_t mode, input logic last_blk);
        logic [15:0][31:0] blk;
        logic [63:0][63:0] pairs;
        logic [31:0]       r;
        int                gap;
        for (int i = 0; i < 16; i++) begin
            draw_bits(32, r);
            blk[i] = r;
        end
        pairs = expand_ref(blk);
        for (int j = 0; j < 64; j++) begin
            exp_wj.push_back(pairs[j][63:32]);
            exp_wjj.push_back(pairs[j][31:0]);
            exp_lst.push_back(last_blk && j == 63);
        end
        for (int i = 0; i < 16; i++) begin
            gap = 0;
            if (mode == GAP_RAND) begin
                draw_bits(2, r);
                gap = int'(r);
            end else if (mode == GAP_SLOW_PRE && i >= 1 && i <= 4) begin
                draw_bits(2, r);
                gap = 4 + int'(r);   // next-block words trickle in
            end
            send_word(blk[i], last_blk && i == 15, gap);
        end
        blocks_sent++;
    endtask

    task automatic send_message(input int n_blocks, input gap_mode_t mode);
        for (int b = 0; b < n_blocks; b++) begin
            send_block(mode, b == n_blocks - 1);
        end
        @(negedge clk);
        pad_vld_i = 1'b0;
        pad_lst_i = 1'b0;
        while (exp_wj.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (pad_rdy_o !== 1'b1) begin
            other_cnt++;
            $display("error at %0t: core not ready after end of message", $time);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : check_pairs
        string tag;
        if (rst_n && expnd_lst_o && !expnd_vld_o) begin
            other_cnt++;
            $display("error at %0t: last strobe high without a valid pair", $time);
        end
        if (rst_n && expnd_vld_o) begin
            if (exp_wj.size() == 0) begin
                other_cnt++;
                $display("error at %0t: output pair with nothing expected", $time);
            end else begin
                tag = $sformatf("block %0d pair %0d", pair_cnt / 64, pair_cnt % 64);
                check_value({tag, " wj"}, expnd_wj_o, exp_wj.pop_front());
                check_value({tag, " wjj"}, expnd_wjj_o, exp_wjj.pop_front());
                check_value({tag, " lst"}, {31'd0, expnd_lst_o}, {31'd0, exp_lst.pop_front()});
            end
            pair_cnt++;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: %0d mismatches, %0d other failures, %0d pairs seen",
                 mismatch_cnt, other_cnt, pair_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        rst_n      = 1'b0;
        pad_word_i = '0;
        pad_vld_i  = 1'b0;
        pad_lst_i  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        send_message(1, GAP_NONE);       // single block, valid held
        send_message(2, GAP_RAND);
        send_message(3, GAP_NONE);       // prefetch and rapid load
        send_message(2, GAP_SLOW_PRE);   // wait state path
        send_message(1, GAP_RAND);       // fresh message from idle

        check_value("pair count", pair_cnt, 64 * blocks_sent);

        $display("errors: %0d mismatches, %0d other failures, %0d pairs seen",
                 mismatch_cnt, other_cnt, pair_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    localparam time HALF_PERIOD = 5ns;   // 10 ns clock

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #HALF_PERIOD;
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== hw/sm3_expnd_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm3_expnd_core (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire sm3_expnd_pkg::word_t    pad_word_i,
    input  wire                          pad_vld_i,
    input  wire                          pad_lst_i,
    output logic                         pad_rdy_o,
    output sm3_expnd_pkg::word_t         expnd_wj_o,
    output sm3_expnd_pkg::word_t         expnd_wjj_o,
    output logic                         expnd_vld_o,
    output logic                         expnd_lst_o
);

    logic                                                 prefetch_wr;
    logic [sm3_expnd_pkg::PRE_CNT_W-1:0]                  prefetch_cnt;
    logic                                                 win_shift;
    logic                                                 win_from_input;
    logic                                                 rapid_load;
    logic                                                 pair_vld;
    logic                                                 pair_lst;
    sm3_expnd_pkg::ctrl_state_t                           ctrl_state;
    sm3_expnd_pkg::word_t [sm3_expnd_pkg::PRE_BUFF_N-1:0] pre_words;
    sm3_expnd_pkg::word_t                                 win_wj;
    sm3_expnd_pkg::word_t                                 win_wjp4;

    sm3_expnd_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .pad_vld_i        (pad_vld_i),
        .pad_lst_i        (pad_lst_i),
        .prefetch_cnt_i   (prefetch_cnt),
        .pad_rdy_o        (pad_rdy_o),
        .prefetch_wr_o    (prefetch_wr),
        .rapid_load_o     (rapid_load),
        .win_shift_o      (win_shift),
        .win_from_input_o (win_from_input),
        .pair_vld_o       (pair_vld),
        .pair_lst_o       (pair_lst),
        .state_o          (ctrl_state)
    );

    // next block w0..w3 while the window still expands
    sm3_prefetch_buf u_prefetch_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (prefetch_wr),
        .clr_i       (rapid_load),
        .word_i      (pad_word_i),
        .pre_words_o (pre_words),
        .cnt_o       (prefetch_cnt)
    );

    sm3_word_window u_word_window (
        .clk          (clk),
        .rst_n        (rst_n),
        .shift_i      (win_shift),
        .from_input_i (win_from_input),
        .rapid_load_i (rapid_load),
        .word_i       (pad_word_i),
        .pre_words_i  (pre_words),
        .wj_o         (win_wj),
        .wjp4_o       (win_wjp4)
    );

    sm3_expnd_out u_expnd_out (
        .clk         (clk),
        .rst_n       (rst_n),
        .wj_i        (win_wj),
        .wjp4_i      (win_wjp4),
        .pair_vld_i  (pair_vld),
        .pair_lst_i  (pair_lst),
        .state_i     (ctrl_state),
        .expnd_wj_o  (expnd_wj_o),
        .expnd_wjj_o (expnd_wjj_o),
        .expnd_vld_o (expnd_vld_o),
        .expnd_lst_o (expnd_lst_o)
    );

endmodule

`default_nettype wire

// ==== hw/sm3_expnd_out.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm3_expnd_out (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire sm3_expnd_pkg::word_t           wj_i,
    input  wire sm3_expnd_pkg::word_t           wjp4_i,
    input  wire                                 pair_vld_i,
    input  wire                                 pair_lst_i,
    input  wire sm3_expnd_pkg::ctrl_state_t     state_i,
    output sm3_expnd_pkg::word_t                expnd_wj_o,
    output sm3_expnd_pkg::word_t                expnd_wjj_o,
    output logic                                expnd_vld_o,
    output logic                                expnd_lst_o
);

    sm3_expnd_pkg::word_t wjj;

    assign wjj = wj_i ^ wjp4_i;   // W'_j

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expnd_vld_o <= 1'b0;
            expnd_lst_o <= 1'b0;
        end else begin
            expnd_vld_o <= pair_vld_i;
            expnd_lst_o <= pair_lst_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expnd_wj_o  <= '0;
            expnd_wjj_o <= '0;
        end else if (pair_vld_i) begin
            expnd_wj_o  <= wj_i;
            expnd_wjj_o <= wjj;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sm3_word_window.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm3_word_window (
    input  wire                                                  clk,
    input  wire                                                  rst_n,
    input  wire                                                  shift_i,
    input  wire                                                  from_input_i,
    input  wire                                                  rapid_load_i,
    input  wire sm3_expnd_pkg::word_t                            word_i,
    input  wire sm3_expnd_pkg::word_t [sm3_expnd_pkg::PRE_BUFF_N-1:0] pre_words_i,
    output sm3_expnd_pkg::word_t                                 wj_o,
    output sm3_expnd_pkg::word_t                                 wjp4_o
);

    sm3_expnd_pkg::word_t win_q [sm3_expnd_pkg::BLK_WORDS];
    sm3_expnd_pkg::word_t p1_in;
    sm3_expnd_pkg::word_t exp_word;
    sm3_expnd_pkg::word_t new_word;

    function automatic sm3_expnd_pkg::word_t rotl(
        input sm3_expnd_pkg::word_t x,
        input int unsigned          n
    );
        rotl = (x << n) | (x >> (sm3_expnd_pkg::WORD_W - n));
    endfunction

    function automatic sm3_expnd_pkg::word_t p1(input sm3_expnd_pkg::word_t x);
        p1 = x ^ rotl(x, 15) ^ rotl(x, 23);
    endfunction

    // slot 15 holds W_{j-1}, so slot k holds W_{j-16+k}
    assign p1_in    = win_q[0] ^ win_q[7] ^ rotl(win_q[13], 15);
    assign exp_word = p1(p1_in) ^ rotl(win_q[3], 7) ^ win_q[10];

    assign new_word = from_input_i ? word_i : exp_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sm3_expnd_pkg::BLK_WORDS; i++) begin
                win_q[i] <= '0;
            end
        end else if (shift_i) begin
            for (int i = 0; i < sm3_expnd_pkg::BLK_WORDS - 1; i++) begin
                win_q[i] <= win_q[i+1];
            end
            win_q[sm3_expnd_pkg::BLK_WORDS-1] <= new_word;
        end else if (rapid_load_i) begin
            // next block w0..w3 from the buffer, w4 straight from input
            for (int i = 0; i < sm3_expnd_pkg::PRE_BUFF_N; i++) begin
                win_q[sm3_expnd_pkg::WIN_OUT+i] <= pre_words_i[i];
            end
            win_q[sm3_expnd_pkg::BLK_WORDS-1] <= word_i;
        end
    end

    assign wj_o   = win_q[sm3_expnd_pkg::WIN_OUT];
    assign wjp4_o = win_q[sm3_expnd_pkg::BLK_WORDS-1];   // W_{j+4}

endmodule

`default_nettype wire

// ==== hw/sm3_prefetch_buf.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm3_prefetch_buf (
    input  wire                                                  clk,
    input  wire                                                  rst_n,
    input  wire                                                  wr_i,
    input  wire                                                  clr_i,
    input  wire sm3_expnd_pkg::word_t                            word_i,
    output sm3_expnd_pkg::word_t [sm3_expnd_pkg::PRE_BUFF_N-1:0] pre_words_o,
    output logic [sm3_expnd_pkg::PRE_CNT_W-1:0]                  cnt_o
);

    sm3_expnd_pkg::word_t [sm3_expnd_pkg::PRE_BUFF_N-1:0] pre_q;
    logic [sm3_expnd_pkg::PRE_CNT_W-1:0]                  cnt_q;

    // oldest word ends up at index 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_q <= '0;
        end else if (wr_i) begin
            pre_q <= {word_i, pre_q[sm3_expnd_pkg::PRE_BUFF_N-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;   // words moved into the window
        end else if (wr_i && cnt_q != sm3_expnd_pkg::PRE_FULL) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign pre_words_o = pre_q;
    assign cnt_o       = cnt_q;

endmodule

`default_nettype wire

// ==== hw/sm3_expnd_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module sm3_expnd_ctrl (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  pad_vld_i,
    input  wire                                  pad_lst_i,
    input  wire [sm3_expnd_pkg::PRE_CNT_W-1:0]   prefetch_cnt_i,
    output logic                                 pad_rdy_o,
    output logic                                 prefetch_wr_o,
    output logic                                 rapid_load_o,
    output logic                                 win_shift_o,
    output logic                                 win_from_input_o,
    output logic                                 pair_vld_o,
    output logic                                 pair_lst_o,
    output sm3_expnd_pkg::ctrl_state_t           state_o
);

    sm3_expnd_pkg::ctrl_state_t              state_q;
    sm3_expnd_pkg::ctrl_state_t              state_d;
    logic [sm3_expnd_pkg::WCNT_W-1:0]        word_cnt_q;
    logic [sm3_expnd_pkg::EXP_CNT_W-1:0]     exp_cnt_q;
    logic                                    lst_blk_q;
    logic                                    accept;
    logic                                    pre_full;
    logic                                    load_st;
    logic                                    prefetch_st;
    logic                                    exp_last;
    logic                                    exp_act;

    assign pre_full    = prefetch_cnt_i == sm3_expnd_pkg::PRE_FULL;
    assign load_st     = state_q inside {sm3_expnd_pkg::IDLE, sm3_expnd_pkg::LOAD_FIRST,
                                         sm3_expnd_pkg::LOAD_OUT};
    assign prefetch_st = state_q inside {sm3_expnd_pkg::EXPND_PREFETCH,
                                         sm3_expnd_pkg::WAIT_PREFETCH};

    // 53rd expansion cycle is the first one spent in the wait state
    assign exp_last = state_q == sm3_expnd_pkg::WAIT_PREFETCH
                   && exp_cnt_q == sm3_expnd_pkg::EXP_CNT_LAST;
    assign exp_act  = state_q == sm3_expnd_pkg::EXPND
                   || state_q == sm3_expnd_pkg::EXPND_PREFETCH
                   || exp_last;

    always_comb begin
        case (state_q)
            sm3_expnd_pkg::EXPND: begin
                pad_rdy_o = 1'b0;   // window busy expanding
            end
            sm3_expnd_pkg::EXPND_PREFETCH,
            sm3_expnd_pkg::WAIT_PREFETCH: begin
                pad_rdy_o = !pre_full;
            end
            default: begin
                pad_rdy_o = 1'b1;
            end
        endcase
    end

    assign accept = pad_vld_i && pad_rdy_o;

    assign prefetch_wr_o    = prefetch_st && accept;
    assign rapid_load_o     = state_q == sm3_expnd_pkg::RAPID_LOAD && accept;
    assign win_from_input_o = load_st;
    assign win_shift_o      = (load_st && accept) || exp_act;
    assign pair_vld_o       = (state_q == sm3_expnd_pkg::LOAD_OUT && accept) || exp_act;
    assign pair_lst_o       = exp_last && lst_blk_q;
    assign state_o          = state_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            sm3_expnd_pkg::IDLE: begin
                if (accept) begin
                    state_d = sm3_expnd_pkg::LOAD_FIRST;
                end
            end
            sm3_expnd_pkg::LOAD_FIRST: begin
                if (accept && word_cnt_q == sm3_expnd_pkg::WCNT_PRE_LAST) begin
                    state_d = sm3_expnd_pkg::LOAD_OUT;
                end
            end
            sm3_expnd_pkg::LOAD_OUT: begin
                if (accept && word_cnt_q == sm3_expnd_pkg::WCNT_BLK_LAST) begin
                    state_d = sm3_expnd_pkg::EXPND;
                end
            end
            sm3_expnd_pkg::EXPND: begin
                if (exp_cnt_q == sm3_expnd_pkg::EXP_CNT_PRE) begin
                    state_d = sm3_expnd_pkg::EXPND_PREFETCH;
                end
            end
            sm3_expnd_pkg::EXPND_PREFETCH: begin
                if (exp_cnt_q == sm3_expnd_pkg::EXP_CNT_LAST - 1'b1) begin
                    state_d = sm3_expnd_pkg::WAIT_PREFETCH;
                end
            end
            sm3_expnd_pkg::WAIT_PREFETCH: begin
                if (pre_full) begin
                    state_d = sm3_expnd_pkg::RAPID_LOAD;
                end else if (prefetch_cnt_i == '0 && !accept) begin
                    state_d = sm3_expnd_pkg::IDLE;   // nothing of the next block yet
                end
            end
            sm3_expnd_pkg::RAPID_LOAD: begin
                if (accept) begin
                    state_d = sm3_expnd_pkg::LOAD_OUT;   // w4 arrived
                end
            end
            default: begin
                state_d = sm3_expnd_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= sm3_expnd_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // wraps after w15, prefetch words count as w0..w3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt_q <= '0;
        end else if (accept) begin
            word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_cnt_q <= '0;
        end else if (exp_last) begin
            exp_cnt_q <= '0;
        end else if (exp_act) begin
            exp_cnt_q <= exp_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst_blk_q <= 1'b0;
        end else if (accept && pad_lst_i) begin
            lst_blk_q <= 1'b1;
        end else if (pair_lst_o) begin
            lst_blk_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/sm3_expnd_pkg.sv ====
`default_nettype none

package sm3_expnd_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    localparam int BLK_WORDS  = 16;
    localparam int OUT_PAIRS  = 64;
    localparam int PRE_WORDS  = 5;   // w0..w4 before the first pair
    localparam int PRE_BUFF_N = 4;
    localparam int PRE_CNT_W  = 3;

    // W16..W67, W67 only feeds W'63
    localparam int EXPND_ROUNDS = OUT_PAIRS + PRE_BUFF_N - BLK_WORDS;

    localparam int WCNT_W    = $clog2(BLK_WORDS);
    localparam int EXP_CNT_W = $clog2(EXPND_ROUNDS + 1);
    localparam int WIN_OUT   = BLK_WORDS - PRE_WORDS;   // window slot of W_j

    localparam logic [WCNT_W-1:0]    WCNT_PRE_LAST = WCNT_W'(PRE_WORDS - 1);
    localparam logic [WCNT_W-1:0]    WCNT_BLK_LAST = WCNT_W'(BLK_WORDS - 1);
    localparam logic [EXP_CNT_W-1:0] EXP_CNT_PRE   = EXP_CNT_W'(EXPND_ROUNDS - PRE_BUFF_N);
    localparam logic [EXP_CNT_W-1:0] EXP_CNT_LAST  = EXP_CNT_W'(EXPND_ROUNDS);
    localparam logic [PRE_CNT_W-1:0] PRE_FULL      = PRE_CNT_W'(PRE_BUFF_N);

    // one-hot controller states
    typedef enum logic [6:0] {
        IDLE           = 7'b000_0001,
        LOAD_FIRST     = 7'b000_0010,   // w0..w4
        LOAD_OUT       = 7'b000_0100,   // w5..w15, one pair per word
        EXPND          = 7'b000_1000,
        EXPND_PREFETCH = 7'b001_0000,
        WAIT_PREFETCH  = 7'b010_0000,
        RAPID_LOAD     = 7'b100_0000
    } ctrl_state_t;

endpackage

`default_nettype wire
